// ==== exeStage.f ====
cpuPkg.sv
aluIf.sv
countBit.sv
alu.sv
operandStage.sv
resultStage.sv
exeTop.sv
exeTop_properties.sv
tbExeTop.sv

// ==== tbExeTop.sv ====
/*
 * testbench for the execute stage
 * random stimulus checked against a two-slot pipeline model
 */
`timescale 1ns/1ps

module tbExeTop;

    localparam int DRAIN_LIMIT = 20;

    logic               clk = 1'b0;
    logic               rst;
    logic               stall;
    logic               flush;
    logic               idValid;
    cpuPkg::aluOp_t     idAluOp;
    cpuPkg::word_t      idRs;
    cpuPkg::word_t      idRt;
    cpuPkg::imm_t       idImm;
    cpuPkg::shamt_t     idShamt;
    logic               idSrcBImm;
    logic               idZeroExt;
    logic               idShiftImm;
    logic               idRegWrite;
    cpuPkg::exceptVec_t idExcept;
    logic               memValid;
    cpuPkg::word_t      memAluOut;
    cpuPkg::exceptVec_t memExcept;
    logic               memExceptHit;
    cpuPkg::excCode_t   memExceptCode;
    logic               memRegWrite;

    // model slots where EXE holds results already computed
    logic               modelExeValid = 1'b0;
    cpuPkg::word_t      modelExeOut;
    cpuPkg::exceptVec_t modelExeExcept;
    logic               modelExeRegWrite;
    logic               modelMemValid = 1'b0;
    cpuPkg::word_t      modelMemOut;
    cpuPkg::exceptVec_t modelMemExcept;
    logic               modelMemRegWrite;
    cpuPkg::word_t      opA;
    cpuPkg::word_t      opB;
    logic [5:0]         expPrio;

    logic [31:0] rngState = 32'd69690;
    int          checkCount = 0;
    int          errCount = 0;
    int          testCount = 0;
    int          testFails = 0;

    exeTop i_exeTop (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int leadCount(input logic [31:0] w, input logic level);
        int n;
        n = 0;
        while (n < 32 && w[31-n] == level) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] modelAlu(input cpuPkg::aluOp_t op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0] sh;
        sh = a[4:0];
        case (op)
            cpuPkg::ALU_ADD, cpuPkg::ALU_ADDU: return a + b;
            cpuPkg::ALU_SUB, cpuPkg::ALU_SUBU: return a + ~b + 32'd1;
            cpuPkg::ALU_OR:                    return a | b;
            cpuPkg::ALU_NOR:                   return ~(a | b);
            cpuPkg::ALU_XOR:                   return a ^ b;
            cpuPkg::ALU_AND:                   return a & b;
            cpuPkg::ALU_SLL, cpuPkg::ALU_SLLV: return b << sh;
            cpuPkg::ALU_SRL, cpuPkg::ALU_SRLV: return b >> sh;
            cpuPkg::ALU_SRA, cpuPkg::ALU_SRAV: begin
                return (b >> sh) | (b[31] ? ~(32'hffffffff >> sh) : 32'h0);  // fill with sign
            end
            cpuPkg::ALU_SLT:  return {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
            cpuPkg::ALU_SLTU: return {31'b0, a < b};
            cpuPkg::ALU_CLZ:  return leadCount(a, 1'b0);
            cpuPkg::ALU_CLO:  return leadCount(a, 1'b1);
            default:          return 32'h0;
        endcase
    endfunction

    // exact signed result of the trapping forms against the 32-bit range
    function automatic logic overflowFor(input cpuPkg::aluOp_t op, input logic [31:0] a,
                                         input logic [31:0] b);
        longint sa;
        longint sb;
        longint r;
        sa = $signed(a);
        sb = $signed(b);
        if (op == cpuPkg::ALU_ADD) r = sa + sb;
        else if (op == cpuPkg::ALU_SUB) r = sa - sb;
        else return 1'b0;
        return (r > 64'sd2147483647) || (r < -64'sd2147483648);
    endfunction

    // {hit, code} of the first raised source in priority order
    function automatic logic [5:0] priorityCode(input cpuPkg::exceptVec_t v);
        int               bitPos [9];
        cpuPkg::excCode_t codes [9];
        bitPos = '{cpuPkg::EX_INTERRUPT, cpuPkg::EX_ADDR_IF, cpuPkg::EX_RESERVED,
                   cpuPkg::EX_OVERFLOW, cpuPkg::EX_SYSCALL, cpuPkg::EX_BREAK, cpuPkg::EX_ERET,
                   cpuPkg::EX_ADDR_RD_MEM, cpuPkg::EX_ADDR_WR_MEM};
        codes = '{cpuPkg::EXC_INT, cpuPkg::EXC_ADEL, cpuPkg::EXC_RI, cpuPkg::EXC_OV,
                  cpuPkg::EXC_SYS, cpuPkg::EXC_BP, cpuPkg::EXC_ERET, cpuPkg::EXC_ADEL,
                  cpuPkg::EXC_ADES};
        for (int i = 0; i < 9; i++) begin
            if (v[bitPos[i]]) return {1'b1, codes[i]};
        end
        return 6'h0;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // mode selects the instruction mix for one cycle of stimulus
    task automatic driveCycle(input int mode);
        logic [31:0]        r;
        logic [31:0]        s;
        logic [31:0]        rs;
        logic [31:0]        rt;
        cpuPkg::aluOp_t     op;
        cpuPkg::exceptVec_t exc;
        logic               shiftImm;
        r = nextRand();
        s = nextRand();
        rs = nextRand();
        rt = nextRand();
        op = r[4:0];
        exc = '0;
        shiftImm = 1'b0;
        case (mode)
            1, 5: begin
                op = r[3:0] % 10;
                if (op > 5) op = op + 5'd6;  // skip the shift group
                if (mode == 5) exc = r[20] ? s[8:0] : (r[13:5] & s[30:22]);
            end
            2: begin
                op = cpuPkg::ALU_SLL + (r[3:0] % 6);
                shiftImm = !op[0];           // even codes take idShamt
                if (r[8]) rt[31] = 1'b1;
            end
            3: begin
                op = r[1:0];
                rs = r[2] ? 32'h7fffffff : 32'h80000000;
                rt = r[3] ? 32'h7fffffff : 32'h80000000;
                if (r[5:4] == 2'd0) rt = 32'h1;
                else if (r[5:4] == 2'd1) rt = 32'hffffffff;
            end
            4: begin
                op = r[0] ? cpuPkg::ALU_CLO : cpuPkg::ALU_CLZ;
                case (r[3:1])
                    3'd0: rs = 32'h0;
                    3'd1: rs = 32'hffffffff;
                    3'd2: rs = 32'h1 << r[8:4];
                    3'd3: rs = ~(32'h1 << r[8:4]);
                    3'd4: rs = rs >> r[8:4];
                    3'd5: rs = ~(rs >> r[8:4]);
                    default: ;
                endcase
            end
            default: begin
                shiftImm = r[7];
                exc = (r[12:9] == 4'd0) ? s[8:0] : '0;
            end
        endcase
        idValid    <= (mode == 6) ? (r[31] | r[30]) : (r[31:29] != 3'd0);
        idAluOp    <= op;
        idRs       <= rs;
        idRt       <= rt;
        idImm      <= s[15:0];
        idShamt    <= s[20:16];
        idSrcBImm  <= (mode == 1 || mode >= 5) ? r[5] : 1'b0;
        idZeroExt  <= r[6];
        idShiftImm <= shiftImm;
        idRegWrite <= r[28] | r[27];
        idExcept   <= exc;
        stall      <= (mode == 6) && (r[15:14] == 2'd0);
        flush      <= (mode == 6) && (r[19:16] == 4'd0);
    endtask

    task automatic drainPipe();
        int waited;
        @(posedge clk);
        idValid <= 1'b0;
        stall   <= 1'b0;
        flush   <= 1'b0;
        waited = 0;
        @(negedge clk);
        while ((memValid || modelExeValid || modelMemValid) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("timeout: pipeline still busy after %0d cycles", DRAIN_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    endtask

    task automatic runTest(input string name, input int mode, input int cycles);
        int errBefore;
        int checksBefore;
        errBefore = errCount;
        checksBefore = checkCount;
        repeat (cycles) begin
            @(posedge clk);
            driveCycle(mode);
        end
        drainPipe();
        testCount++;
        if (errCount != errBefore) testFails++;
        $display("test %s: %0d checks, %0d errors", name, checkCount - checksBefore,
                 errCount - errBefore);
    endtask

    task automatic resetTest(input string name);
        int errBefore;
        errBefore = errCount;
        rst     <= 1'b1;
        idValid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("memValid", memValid, 32'h0);
        checkValue("memRegWrite", memRegWrite, 32'h0);
        checkValue("memExceptHit", memExceptHit, 32'h0);
        checkValue("memAluOut", memAluOut, 32'h0);
        checkValue("memExceptCode", memExceptCode, 32'h0);
        testCount++;
        if (errCount != errBefore) testFails++;
        $display("test %s: %0d errors", name, errCount - errBefore);
    endtask

    // reference pipeline updates the MEM slot first so it takes the old EXE contents
    always @(posedge clk) begin
        if (rst) begin
            modelExeValid = 1'b0;
            modelMemValid = 1'b0;
        end else begin
            if (flush) begin
                modelMemValid = 1'b0;
            end else if (!stall) begin
                modelMemValid    = modelExeValid;
                modelMemOut      = modelExeOut;
                modelMemExcept   = modelExeExcept;
                modelMemRegWrite = modelExeRegWrite;
            end
            if (flush) begin
                modelExeValid = 1'b0;
            end else if (!stall) begin
                opA = idShiftImm ? {27'b0, idShamt} : idRs;
                opB = !idSrcBImm ? idRt : (idZeroExt ? {16'h0, idImm} : {{16{idImm[15]}}, idImm});
                modelExeValid    = idValid;
                modelExeOut      = modelAlu(idAluOp, opA, opB);
                modelExeExcept   = idExcept;
                modelExeExcept[cpuPkg::EX_OVERFLOW] = overflowFor(idAluOp, opA, opB);
                modelExeRegWrite = idRegWrite;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checkValue("memValid", memValid, modelMemValid);
            if (memValid && modelMemValid) begin
                expPrio = priorityCode(modelMemExcept);
                checkValue("memAluOut", memAluOut, modelMemOut);
                checkValue("memExcept", memExcept, modelMemExcept);
                checkValue("memExceptHit", memExceptHit, expPrio[5]);
                checkValue("memExceptCode", memExceptCode, expPrio[4:0]);
                checkValue("memRegWrite", memRegWrite, modelMemRegWrite && !expPrio[5]);
            end
        end
    end

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        idValid    = 1'b0;
        idAluOp    = '0;
        idRs       = '0;
        idRt       = '0;
        idImm      = '0;
        idShamt    = '0;
        idSrcBImm  = 1'b0;
        idZeroExt  = 1'b0;
        idShiftImm = 1'b0;
        idRegWrite = 1'b0;
        idExcept   = '0;
        resetTest("reset");
        runTest("arith", 1, 300);
        runTest("shift", 2, 200);
        runTest("overflow", 3, 100);
        runTest("count", 4, 150);
        runTest("except", 5, 200);
        runTest("stallFlush", 6, 500);
        @(posedge clk);
        resetTest("resetAgain");
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, testFails, checkCount, errCount,
                 i_exeTop.i_exeTopProperties.failCount);
        if (errCount == 0 && i_exeTop.i_exeTopProperties.failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== exeTop_properties.sv ====
/*
 * concurrent checks on the execute stage outputs
 * stall hold, flush, reset and write-back gating
 */
`timescale 1ns/1ps

module exeTopProperties (
    input logic               clk,
    input logic               rst,
    input logic               stall,
    input logic               flush,
    input logic               memValid,
    input cpuPkg::word_t      memAluOut,
    input cpuPkg::exceptVec_t memExcept,
    input logic               memExceptHit,
    input cpuPkg::excCode_t   memExceptCode,
    input logic               memRegWrite
);

    int failCount = 0;  // read by the testbench at the end of the run

    // a stalled edge leaves every output as it was
    stallHold: assert property (@(posedge clk) (stall && !flush && !rst) |=>
        $stable(memValid) && $stable(memAluOut) && $stable(memExcept) &&
        $stable(memExceptHit) && $stable(memExceptCode) && $stable(memRegWrite))
        else begin
            failCount++;
            $error("outputs changed during stall");
        end

    flushKill: assert property (@(posedge clk) flush |=> !memValid)
        else begin
            failCount++;
            $error("memValid high after flush");
        end

    hitNoWrite: assert property (@(posedge clk) disable iff (rst)
        !(memExceptHit && memRegWrite))
        else begin
            failCount++;
            $error("write-back enabled for an excepting instruction");
        end

    resetClear: assert property (@(posedge clk) rst |=> !memValid && !memRegWrite && !memExceptHit)
        else begin
            failCount++;
            $error("outputs not cleared by reset");
        end

endmodule

bind exeTop exeTopProperties i_exeTopProperties (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .flush         (flush),
    .memValid      (memValid),
    .memAluOut     (memAluOut),
    .memExcept     (memExcept),
    .memExceptHit  (memExceptHit),
    .memExceptCode (memExceptCode),
    .memRegWrite   (memRegWrite)
);

// ==== exeTop.sv ====
/*
 * execute stage top
 * ID/EXE register, ALU and EXE/MEM register on one bus
 */
`timescale 1ns/1ps

module exeTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,

    // from decode
    input  logic                idValid,
    input  cpuPkg::aluOp_t      idAluOp,
    input  cpuPkg::word_t       idRs,
    input  cpuPkg::word_t       idRt,
    input  cpuPkg::imm_t        idImm,
    input  cpuPkg::shamt_t      idShamt,
    input  logic                idSrcBImm,
    input  logic                idZeroExt,
    input  logic                idShiftImm,
    input  logic                idRegWrite,
    input  cpuPkg::exceptVec_t  idExcept,

    // to memory stage
    output logic                memValid,
    output cpuPkg::word_t       memAluOut,
    output cpuPkg::exceptVec_t  memExcept,
    output logic                memExceptHit,
    output cpuPkg::excCode_t    memExceptCode,
    output logic                memRegWrite
);

    aluIf exeBus ();

    operandStage i_operandStage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .idValid    (idValid),
        .idAluOp    (idAluOp),
        .idRs       (idRs),
        .idRt       (idRt),
        .idImm      (idImm),
        .idShamt    (idShamt),
        .idSrcBImm  (idSrcBImm),
        .idZeroExt  (idZeroExt),
        .idShiftImm (idShiftImm),
        .idRegWrite (idRegWrite),
        .idExcept   (idExcept),
        .exe        (exeBus.src)
    );

    // purely combinational, no clock
    alu i_alu (
        .exe (exeBus.unit)
    );

    resultStage i_resultStage (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .exe           (exeBus.sink),
        .memValid      (memValid),
        .memAluOut     (memAluOut),
        .memExcept     (memExcept),
        .memExceptHit  (memExceptHit),
        .memExceptCode (memExceptCode),
        .memRegWrite   (memRegWrite)
    );

endmodule

// ==== resultStage.sv ====
/*
 * EXE/MEM pipeline register
 * priority-encodes the exception vector and blocks
 * write-back for excepting instructions
 */
`timescale 1ns/1ps

module resultStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    aluIf.sink                  exe,
    output logic                memValid,
    output cpuPkg::word_t       memAluOut,
    output cpuPkg::exceptVec_t  memExcept,
    output logic                memExceptHit,
    output cpuPkg::excCode_t    memExceptCode,
    output logic                memRegWrite
);

    logic             hit;
    cpuPkg::excCode_t code;

    // first set bit wins, interrupt highest
    always_comb begin
        hit  = 1'b1;
        code = cpuPkg::EXC_INT;
        if (exe.exceptOut[cpuPkg::EX_INTERRUPT])        code = cpuPkg::EXC_INT;
        else if (exe.exceptOut[cpuPkg::EX_ADDR_IF])     code = cpuPkg::EXC_ADEL;
        else if (exe.exceptOut[cpuPkg::EX_RESERVED])    code = cpuPkg::EXC_RI;
        else if (exe.exceptOut[cpuPkg::EX_OVERFLOW])    code = cpuPkg::EXC_OV;
        else if (exe.exceptOut[cpuPkg::EX_SYSCALL])     code = cpuPkg::EXC_SYS;
        else if (exe.exceptOut[cpuPkg::EX_BREAK])       code = cpuPkg::EXC_BP;
        else if (exe.exceptOut[cpuPkg::EX_ERET])        code = cpuPkg::EXC_ERET;
        else if (exe.exceptOut[cpuPkg::EX_ADDR_RD_MEM]) code = cpuPkg::EXC_ADEL;
        else if (exe.exceptOut[cpuPkg::EX_ADDR_WR_MEM]) code = cpuPkg::EXC_ADES;
        else hit = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memValid      <= 1'b0;
            memRegWrite   <= 1'b0;
            memExceptHit  <= 1'b0;
            memAluOut     <= '0;
            memExcept     <= '0;
            memExceptCode <= '0;
        end else begin
            if (flush) begin
                memValid     <= 1'b0;
                memRegWrite  <= 1'b0;
                memExceptHit <= 1'b0;
            end else if (!stall) begin
                memValid     <= exe.valid;
                memRegWrite  <= exe.valid && exe.regWrite && !hit;
                memExceptHit <= exe.valid && hit;
            end

            if (!stall) begin
                memAluOut     <= exe.aluOut;
                memExcept     <= exe.exceptOut;
                memExceptCode <= (exe.valid && hit) ? code : '0;  // zero when nothing raised
            end
        end
    end

endmodule

// ==== operandStage.sv ====
/*
 * ID/EXE pipeline register
 * builds ALU operands from registers, immediate and shift amount
 */
`timescale 1ns/1ps

module operandStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic                idValid,
    input  cpuPkg::aluOp_t      idAluOp,
    input  cpuPkg::word_t       idRs,
    input  cpuPkg::word_t       idRt,
    input  cpuPkg::imm_t        idImm,
    input  cpuPkg::shamt_t      idShamt,
    input  logic                idSrcBImm,
    input  logic                idZeroExt,
    input  logic                idShiftImm,
    input  logic                idRegWrite,
    input  cpuPkg::exceptVec_t  idExcept,
    aluIf.src                   exe
);

    cpuPkg::word_t immExt;
    cpuPkg::word_t operandA;
    cpuPkg::word_t operandB;

    always_comb begin
        // ORI/ANDI/XORI use zero extension, the rest sign extension
        if (idZeroExt) begin
            immExt = {{(cpuPkg::WORD_W - cpuPkg::IMM_W){1'b0}}, idImm};
        end else begin
            immExt = {{(cpuPkg::WORD_W - cpuPkg::IMM_W){idImm[cpuPkg::IMM_W-1]}}, idImm};
        end

        // SLL/SRL/SRA take the amount from the instruction
        operandA = idShiftImm ? {{(cpuPkg::WORD_W - cpuPkg::SHAMT_W){1'b0}}, idShamt}
                              : idRs;
        operandB = idSrcBImm ? immExt : idRt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe.valid     <= 1'b0;
            exe.aluOp     <= '0;
            exe.resultA   <= '0;
            exe.resultB   <= '0;
            exe.exceptIn  <= '0;
            exe.regWrite  <= 1'b0;
            exe.countOnes <= 1'b0;
        end else begin
            // flush wins over stall
            if (flush) begin
                exe.valid <= 1'b0;
            end else if (!stall) begin
                exe.valid <= idValid;
            end

            if (!stall) begin
                exe.aluOp     <= idAluOp;
                exe.resultA   <= operandA;
                exe.resultB   <= operandB;
                exe.exceptIn  <= idExcept;
                exe.regWrite  <= idRegWrite;
                exe.countOnes <= (idAluOp == cpuPkg::ALU_CLO); // counter select
            end
        end
    end

endmodule

// ==== alu.sv ====
/*
 * execute unit
 * add/sub, logic, shifts, set-less-than and bit counts,
 * signed overflow merged into the exception vector
 */
`timescale 1ns/1ps

module alu (
    aluIf.unit exe
);

    cpuPkg::word_t sum;
    cpuPkg::word_t diff;
    cpuPkg::word_t countOut;
    logic          addOverflow;
    logic          subOverflow;
    logic          overflow;

    countBit i_countBit (
        .countOnes (exe.countOnes),
        .value     (exe.resultA),
        .count     (countOut)
    );

    assign sum  = exe.resultA + exe.resultB;
    assign diff = exe.resultA - exe.resultB;

    // same-sign inputs with a flipped result sign
    assign addOverflow = (exe.resultA[31] == exe.resultB[31]) && (sum[31] != exe.resultA[31]);
    // for subtract the operand signs must differ
    assign subOverflow = (exe.resultA[31] != exe.resultB[31]) && (diff[31] != exe.resultA[31]);

    // only the trapping forms raise it
    assign overflow = ((exe.aluOp == cpuPkg::ALU_ADD) && addOverflow) ||
                      ((exe.aluOp == cpuPkg::ALU_SUB) && subOverflow);

    always_comb begin
        case (exe.aluOp)
            cpuPkg::ALU_ADD, cpuPkg::ALU_ADDU: begin
                exe.aluOut = sum;
            end
            cpuPkg::ALU_SUB, cpuPkg::ALU_SUBU: begin
                exe.aluOut = diff;
            end
            cpuPkg::ALU_OR:  exe.aluOut = exe.resultA | exe.resultB;
            cpuPkg::ALU_NOR: exe.aluOut = ~(exe.resultA | exe.resultB);
            cpuPkg::ALU_XOR: exe.aluOut = exe.resultA ^ exe.resultB;
            cpuPkg::ALU_AND: exe.aluOut = exe.resultA & exe.resultB;
            cpuPkg::ALU_SLL, cpuPkg::ALU_SLLV: begin
                exe.aluOut = exe.resultB << exe.resultA[4:0];
            end
            cpuPkg::ALU_SRL, cpuPkg::ALU_SRLV: begin
                exe.aluOut = exe.resultB >> exe.resultA[4:0];
            end
            cpuPkg::ALU_SRA, cpuPkg::ALU_SRAV: begin
                exe.aluOut = $signed(exe.resultB) >>> exe.resultA[4:0];  // sign fill
            end
            cpuPkg::ALU_SLT: begin
                exe.aluOut = {31'b0, $signed(exe.resultA) < $signed(exe.resultB)};
            end
            cpuPkg::ALU_SLTU: begin
                exe.aluOut = {31'b0, exe.resultA < exe.resultB};
            end
            cpuPkg::ALU_CLZ, cpuPkg::ALU_CLO: begin
                exe.aluOut = countOut;  // select comes with the operands
            end
            default: exe.aluOut = '0;   // undefined op
        endcase
    end

    // pass earlier exceptions through, replace the overflow bit
    always_comb begin
        exe.exceptOut                      = exe.exceptIn;
        exe.exceptOut[cpuPkg::EX_OVERFLOW] = overflow;
    end

endmodule

// ==== countBit.sv ====
/*
 * leading bit counter for CLZ and CLO
 * counts from bit 31 down while bits equal countOnes
 */
`timescale 1ns/1ps

module countBit (
    input  logic           countOnes,
    input  cpuPkg::word_t  value,
    output cpuPkg::word_t  count
);

    cpuPkg::word_t matchBits;  // one where value agrees with the counted level
    logic          run;

    always_comb begin
        matchBits = countOnes ? value : ~value;
    end

    // scan from the msb, stop at the first mismatch
    always_comb begin
        count = '0;
        run   = 1'b1;
        for (int i = cpuPkg::WORD_W - 1; i >= 0; i--) begin
            if (run && matchBits[i]) begin
                count = count + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

endmodule

// ==== aluIf.sv ====
/*
 * execute bus between the ID/EXE register, the ALU
 * and the EXE/MEM register
 */
`timescale 1ns/1ps

interface aluIf;

    logic                valid;
    cpuPkg::aluOp_t      aluOp;
    cpuPkg::word_t       resultA;    // operand A
    cpuPkg::word_t       resultB;    // operand B
    cpuPkg::exceptVec_t  exceptIn;   // exceptions from earlier stages
    logic                regWrite;
    logic                countOnes;  // CLO when set, CLZ otherwise
    cpuPkg::word_t       aluOut;
    cpuPkg::exceptVec_t  exceptOut;

    // ID/EXE register side
    modport src (output valid, aluOp, resultA, resultB, exceptIn, regWrite, countOnes);

    // combinational unit
    modport unit (input aluOp, resultA, resultB, exceptIn, countOnes,
                  output aluOut, exceptOut);

    // EXE/MEM register side
    modport sink (input valid, regWrite, aluOut, exceptOut);

endinterface

// ==== cpuPkg.sv ====
/*
 * cpu execute-stage package
 * widths, vector types, ALU opcodes, exception bit positions
 * and MIPS exception codes shared by all stages
 */
package cpuPkg;

    // datapath widths fixed by the instruction set
    localparam int WORD_W     = 32;
    localparam int OP_W       = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int EXCEPT_W   = 9;
    localparam int EXC_CODE_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [OP_W-1:0]       aluOp_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [EXCEPT_W-1:0]   exceptVec_t;
    typedef logic [EXC_CODE_W-1:0] excCode_t;

    // ALU operation selector
    localparam aluOp_t ALU_ADD  = 5'd0;  // trapping
    localparam aluOp_t ALU_ADDU = 5'd1;
    localparam aluOp_t ALU_SUB  = 5'd2;  // trapping
    localparam aluOp_t ALU_SUBU = 5'd3;
    localparam aluOp_t ALU_OR   = 5'd4;
    localparam aluOp_t ALU_NOR  = 5'd5;
    localparam aluOp_t ALU_SLL  = 5'd6;
    localparam aluOp_t ALU_SLLV = 5'd7;
    localparam aluOp_t ALU_SRL  = 5'd8;
    localparam aluOp_t ALU_SRLV = 5'd9;
    localparam aluOp_t ALU_SRA  = 5'd10;
    localparam aluOp_t ALU_SRAV = 5'd11;
    localparam aluOp_t ALU_SLT  = 5'd12;
    localparam aluOp_t ALU_SLTU = 5'd13;
    localparam aluOp_t ALU_XOR  = 5'd14;
    localparam aluOp_t ALU_AND  = 5'd15;
    localparam aluOp_t ALU_CLZ  = 5'd16;
    localparam aluOp_t ALU_CLO  = 5'd17;

    // bit positions inside exceptVec_t
    localparam int EX_INTERRUPT   = 0;
    localparam int EX_ADDR_IF     = 1;
    localparam int EX_RESERVED    = 2;
    localparam int EX_SYSCALL     = 3;
    localparam int EX_BREAK       = 4;
    localparam int EX_ERET        = 5;
    localparam int EX_ADDR_WR_MEM = 6;
    localparam int EX_ADDR_RD_MEM = 7;
    localparam int EX_OVERFLOW    = 8;

    // cause register ExcCode values
    localparam excCode_t EXC_INT  = 5'd0;
    localparam excCode_t EXC_ADEL = 5'd4;   // load or fetch address error
    localparam excCode_t EXC_ADES = 5'd5;   // store address error
    localparam excCode_t EXC_SYS  = 5'd8;
    localparam excCode_t EXC_BP   = 5'd9;
    localparam excCode_t EXC_RI   = 5'd10;
    localparam excCode_t EXC_OV   = 5'd12;

    /*
     * not an architectural code, marks an eret
     * so the handler side can tell it apart
     */
    localparam excCode_t EXC_ERET = 5'd31;

endpackage
